/* flist.f */
+incdir+dv
source/ps2_pkg.sv
source/ps2_rx.sv
source/scan_decoder.sv
source/key_map.sv
source/ps2_keyboard.sv
dv/ps2_keyboard_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= ps2_keyboard_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* dv/ps2_host_model.svh */
`ifndef PS2_HOST_MODEL_SVH
`define PS2_HOST_MODEL_SVH

localparam int PS2_HALF = 40;  // PS/2 clock half period in clk cycles

// Fixed delay on falling clk edges
task automatic skip_cycles(input int n);
    repeat (n) @(negedge clk);
endtask

// Data changes while the PS/2 clock is high as a keyboard does
// Entered on a falling clk edge
task automatic drive_bit(input logic b);
    ps2_data = b;
    skip_cycles(PS2_HALF / 2);
    ps2_clk = 1'b0;  // Receiver samples on this edge
    skip_cycles(PS2_HALF);
    ps2_clk = 1'b1;
    skip_cycles(PS2_HALF / 2);
endtask

// One byte as an 11-bit frame
// Truncated frames stop after start plus four data bits
task automatic send_frame(input logic [7:0] value, input bit bad_parity, input bit truncate);
    logic [10:0] frame;
    logic        parity;
    int          n_bits;
    parity = ~(^value) ^ bad_parity;      // Odd parity flipped on request
    frame  = {1'b1, parity, value, 1'b0};  // Stop, parity, data, start
    n_bits = truncate ? 5 : 11;
    for (int i = 0; i < n_bits; i++) begin
        drive_bit(frame[i]);  // LSB first
    end
    ps2_data = 1'b1;  // Lines back to idle
    ps2_clk  = 1'b1;
endtask

// Random quiet time between frames
task automatic idle_gap();
    int gap;
    gap = 100 + int'($unsigned($random(seed)) % 200);
    skip_cycles(gap);
endtask

`endif

/* dv/ps2_keyboard_tb.sv */
`timescale 1ns/1ns
`default_nettype none

// Rows run back to back, so pressed state carries over between them
module ps2_keyboard_tb import ps2_pkg::*; ();

    localparam int IDLE_TIMEOUT = 400;   // Short watchdog for a fast run
    localparam int POLL_LIMIT   = 2000;  // Cycles per output wait
    localparam int MAX_ROWS     = 32;

    // Single-control masks of the pressed-state word
    localparam logic [JOY_W-1:0] MASK_RIGHT = JOY_W'(1) << JOY_RIGHT;
    localparam logic [JOY_W-1:0] MASK_LEFT  = JOY_W'(1) << JOY_LEFT;
    localparam logic [JOY_W-1:0] MASK_DOWN  = JOY_W'(1) << JOY_DOWN;
    localparam logic [JOY_W-1:0] MASK_UP    = JOY_W'(1) << JOY_UP;
    localparam logic [JOY_W-1:0] MASK_BTN1  = JOY_W'(1) << JOY_BUTTON1;
    localparam logic [JOY_W-1:0] MASK_BTN2  = JOY_W'(1) << JOY_BUTTON2;
    localparam logic [JOY_W-1:0] MASK_COIN  = JOY_W'(1) << JOY_COIN;
    localparam logic [JOY_W-1:0] MASK_START = JOY_W'(1) << JOY_START;

    logic             clk;
    logic             reset;
    logic             ps2_clk;
    logic             ps2_data;
    logic [JOY_W-1:0] joystick;
    logic             rst_req;
    logic [ERR_W-1:0] error_count;
    integer           seed = 32'h404f;

    string            row_name    [MAX_ROWS];
    int               row_len     [MAX_ROWS];  // Bytes used in row_seq
    logic [31:0]      row_seq     [MAX_ROWS];  // First byte in the top bits
    logic [7:0]       row_flags   [MAX_ROWS];  // Per byte {truncate, bad parity}
    logic [JOY_W-1:0] row_pressed [MAX_ROWS];  // 1 = held
    logic             row_rst     [MAX_ROWS];
    logic [ERR_W-1:0] row_errs    [MAX_ROWS];
    int               n_rows = 0;

    `include "ps2_host_model.svh"

    ps2_keyboard #(
        .ACTIVE_LOW   (1'b1),
        .IDLE_TIMEOUT (IDLE_TIMEOUT)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .joystick    (joystick),
        .rst_req     (rst_req),
        .error_count (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    task automatic add_row(input string name, input int len, input logic [31:0] seq,
                           input logic [7:0] flags, input logic [JOY_W-1:0] pressed,
                           input logic rst, input logic [ERR_W-1:0] errs);
        row_name[n_rows]    = name;
        row_len[n_rows]     = len;
        row_seq[n_rows]     = seq;
        row_flags[n_rows]   = flags;
        row_pressed[n_rows] = pressed;
        row_rst[n_rows]     = rst;
        row_errs[n_rows]    = errs;
        n_rows++;
    endtask

    // Scan code set 2 with E0 for extended and F0 for break
    task automatic load_table();
        add_row("reset_state",      0, 32'h00000000, 8'h00, '0, 1'b0, 8'd0);
        add_row("ctrl_make",        1, 32'h14000000, 8'h00, MASK_BTN1, 1'b0, 8'd0);
        add_row("ctrl_break",       2, 32'hF0140000, 8'h00, '0, 1'b0, 8'd0);
        add_row("space_make",       1, 32'h29000000, 8'h00, MASK_BTN2, 1'b0, 8'd0);
        add_row("space_break",      2, 32'hF0290000, 8'h00, '0, 1'b0, 8'd0);
        add_row("coin_make",        1, 32'h2E000000, 8'h00, MASK_COIN, 1'b0, 8'd0);
        add_row("coin_break",       2, 32'hF02E0000, 8'h00, '0, 1'b0, 8'd0);
        add_row("start_make",       1, 32'h16000000, 8'h00, MASK_START, 1'b0, 8'd0);
        add_row("start_break",      2, 32'hF0160000, 8'h00, '0, 1'b0, 8'd0);
        add_row("left_make",        2, 32'hE06B0000, 8'h00, MASK_LEFT, 1'b0, 8'd0);
        add_row("left_break",       3, 32'hE0F06B00, 8'h00, '0, 1'b0, 8'd0);
        add_row("right_make",       2, 32'hE0740000, 8'h00, MASK_RIGHT, 1'b0, 8'd0);
        add_row("right_break",      3, 32'hE0F07400, 8'h00, '0, 1'b0, 8'd0);
        add_row("up_make",          2, 32'hE0750000, 8'h00, MASK_UP, 1'b0, 8'd0);
        add_row("up_break",         3, 32'hE0F07500, 8'h00, '0, 1'b0, 8'd0);
        add_row("down_make",        2, 32'hE0720000, 8'h00, MASK_DOWN, 1'b0, 8'd0);
        add_row("down_break",       3, 32'hE0F07200, 8'h00, '0, 1'b0, 8'd0);
        add_row("plain_6b_ignored", 1, 32'h6B000000, 8'h00, '0, 1'b0, 8'd0);
        add_row("ext_14_ignored",   2, 32'hE0140000, 8'h00, '0, 1'b0, 8'd0);
        add_row("hold_up",          2, 32'hE0750000, 8'h00, MASK_UP, 1'b0, 8'd0);
        add_row("hold_right",       2, 32'hE0740000, 8'h00, MASK_UP|MASK_RIGHT, 1'b0, 8'd0);
        add_row("hold_space", 1, 32'h29000000, 8'h00, MASK_UP|MASK_RIGHT|MASK_BTN2, 1'b0, 8'd0);
        add_row("release_right",    3, 32'hE0F07400, 8'h00, MASK_UP|MASK_BTN2, 1'b0, 8'd0);
        add_row("release_up",       3, 32'hE0F07500, 8'h00, MASK_BTN2, 1'b0, 8'd0);
        add_row("release_space",    2, 32'hF0290000, 8'h00, '0, 1'b0, 8'd0);
        add_row("bad_parity",       1, 32'h29000000, 8'h40, '0, 1'b0, 8'd1);
        add_row("truncated",        1, 32'h29000000, 8'h80, '0, 1'b0, 8'd2);  // Waits out watchdog
        add_row("prefix_cleared",   3, 32'hE0756B00, 8'h10, '0, 1'b0, 8'd3);  // Middle byte bad
        add_row("good_after_error", 1, 32'h14000000, 8'h00, MASK_BTN1, 1'b0, 8'd3);
        add_row("ctrl_release",     2, 32'hF0140000, 8'h00, '0, 1'b0, 8'd3);
        add_row("f3_make",          1, 32'h04000000, 8'h00, '0, 1'b1, 8'd3);
        add_row("f3_break",         2, 32'hF0040000, 8'h00, '0, 1'b0, 8'd3);
    endtask

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_joy(input string name, input logic [JOY_W-1:0] exp,
                             input logic [JOY_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s joystick expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s rst_req expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input logic [ERR_W-1:0] exp,
                               input logic [ERR_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s error_count expected %0d actual %0d", name, exp, act);
            stop_run();
        end
    endtask

    function automatic bit outputs_match(input int r);
        return joystick === ~row_pressed[r] && rst_req === row_rst[r] &&
               error_count === row_errs[r];
    endfunction

    // Poll on falling edges, then report whatever still differs
    task automatic wait_outputs(input int r);
        int cycles;
        cycles = 0;
        while (!outputs_match(r) && cycles < POLL_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!outputs_match(r)) begin
            $display("Timeout: outputs of test %s did not settle within %0d cycles",
                     row_name[r], POLL_LIMIT);
        end
        check_joy(row_name[r], ~row_pressed[r], joystick);  // Active-low cabinet side
        check_flag(row_name[r], row_rst[r], rst_req);
        check_count(row_name[r], row_errs[r], error_count);
    endtask

    initial begin
        reset    = 1'b1;
        ps2_clk  = 1'b1;  // Idle bus
        ps2_data = 1'b1;
        load_table();
        repeat (4) @(negedge clk);
        reset = 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            for (int i = 0; i < row_len[r]; i++) begin
                send_frame(row_seq[r][31 - 8*i -: 8], row_flags[r][6 - 2*i],
                           row_flags[r][7 - 2*i]);
                idle_gap();
            end
            wait_outputs(r);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* source/ps2_keyboard.sv */
`timescale 1ns/1ns
`default_nettype none

// Keyboard input of the arcade core
// PS/2 lines in, control word, reset request and error count out
module ps2_keyboard import ps2_pkg::*; #(
    parameter bit ACTIVE_LOW   = 1'b1,
    parameter int IDLE_TIMEOUT = 2000
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              ps2_clk,
    input  wire              ps2_data,
    output logic [JOY_W-1:0] joystick,
    output logic             rst_req,
    output logic [ERR_W-1:0] error_count
);

    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       rx_error;
    logic [7:0] event_code;
    logic       event_extended;
    logic       event_released;
    logic       event_valid;

    // Line sampling and frame checks
    ps2_rx #(
        .IDLE_TIMEOUT (IDLE_TIMEOUT)
    ) rx0 (
        .clk         (clk),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .rx_error    (rx_error),
        .error_count (error_count)
    );

    scan_decoder dec0 (
        .clk            (clk),
        .reset          (reset),
        .rx_byte        (rx_byte),
        .rx_valid       (rx_valid),
        .rx_error       (rx_error),
        .event_code     (event_code),
        .event_extended (event_extended),
        .event_released (event_released),
        .event_valid    (event_valid)
    );

    key_map #(
        .ACTIVE_LOW (ACTIVE_LOW)
    ) map0 (
        .clk            (clk),
        .reset          (reset),
        .event_code     (event_code),
        .event_extended (event_extended),
        .event_released (event_released),
        .event_valid    (event_valid),
        .joystick       (joystick),
        .rst_req        (rst_req)
    );

endmodule

`default_nettype wire

/* source/key_map.sv */
`timescale 1ns/1ns
`default_nettype none

// Key events to arcade controls
// One pressed bit per control, so several keys can be held at once
module key_map import ps2_pkg::*; #(
    parameter bit ACTIVE_LOW = 1'b1  // Cabinet inputs read 0 when pressed
) (
    input  wire              clk,
    input  wire              reset,
    input  wire  [7:0]       event_code,
    input  wire              event_extended,
    input  wire              event_released,
    input  wire              event_valid,
    output logic [JOY_W-1:0] joystick,
    output logic             rst_req
);

    logic [JOY_W-1:0] pressed;     // 1 = key held
    logic             rst_held;    // F3 state
    logic             make;

    assign make = ~event_released;  // Break code clears the bit

    always_ff @(posedge clk) begin
        if (reset) begin
            pressed  <= '0;
            rst_held <= 1'b0;
        end else if (event_valid) begin
            if (event_extended) begin
                // Arrows live in the E0 page only
                case (event_code)
                    KEY_RIGHT: pressed[JOY_RIGHT] <= make;
                    KEY_LEFT:  pressed[JOY_LEFT]  <= make;
                    KEY_DOWN:  pressed[JOY_DOWN]  <= make;
                    KEY_UP:    pressed[JOY_UP]    <= make;
                    default: begin
                        // Other extended keys ignored
                    end
                endcase
            end else begin
                case (event_code)
                    KEY_CTRL:  pressed[JOY_BUTTON1] <= make;  // Fire
                    KEY_SPACE: pressed[JOY_BUTTON2] <= make;  // Jump
                    KEY_COIN:  pressed[JOY_COIN]    <= make;
                    KEY_START: pressed[JOY_START]   <= make;
                    KEY_RESET: rst_held             <= make;  // Held F3 resets the game
                    default: begin
                        // Unmapped plain keys
                    end
                endcase
            end
        end
    end

    // Polarity for the cabinet side
    assign joystick = ACTIVE_LOW ? ~pressed : pressed;
    assign rst_req  = rst_held;

    // Reset request moves only on a decoded key
    a_rst_req_on_event: assert property (
        @(posedge clk) disable iff (reset)
        $changed(rst_req) |-> $past(event_valid)
    );

endmodule

`default_nettype wire

/* source/scan_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

// Scan code set 2 prefix tracker
// E0 and F0 are folded into flags on the next plain byte
module scan_decoder import ps2_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire  [7:0] rx_byte,
    input  wire        rx_valid,
    input  wire        rx_error,
    output logic [7:0] event_code,
    output logic       event_extended,
    output logic       event_released,
    output logic       event_valid
);

    logic ext_pending;  // E0 seen
    logic rel_pending;  // F0 seen
    logic is_prefix;

    assign is_prefix = (rx_byte == CODE_EXTEND) || (rx_byte == CODE_RELEASE);

    // Prefix flags and event strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            ext_pending <= 1'b0;
            rel_pending <= 1'b0;
            event_valid <= 1'b0;
        end else begin
            event_valid <= 1'b0;
            if (rx_error) begin
                // A lost byte may have been the key itself
                ext_pending <= 1'b0;
                rel_pending <= 1'b0;
            end else if (rx_valid) begin
                if (rx_byte == CODE_EXTEND) begin
                    ext_pending <= 1'b1;
                end else if (rx_byte == CODE_RELEASE) begin
                    rel_pending <= 1'b1;
                end else begin
                    event_valid <= 1'b1;
                    ext_pending <= 1'b0;  // Consumed by this key
                    rel_pending <= 1'b0;
                end
            end
        end
    end

    // Event payload is only meaningful with event_valid
    always_ff @(posedge clk) begin
        if (rx_valid && !is_prefix) begin
            event_code     <= rx_byte;
            event_extended <= ext_pending;
            event_released <= rel_pending;
        end
    end

    // Prefixes must never reach the mapper as keys
    a_no_prefix_event: assert property (
        @(posedge clk) disable iff (reset)
        event_valid |-> (event_code != CODE_EXTEND && event_code != CODE_RELEASE)
    );

endmodule

`default_nettype wire

/* source/ps2_rx.sv */
`timescale 1ns/1ns
`default_nettype none

// PS/2 device-to-host receiver
// Samples the lines with clk, assembles 11-bit frames and checks them
module ps2_rx import ps2_pkg::*; #(
    parameter int IDLE_TIMEOUT = 2000  // Cycles without an edge before a frame is dropped
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              ps2_clk,
    input  wire              ps2_data,
    output logic [7:0]       rx_byte,
    output logic             rx_valid,
    output logic             rx_error,
    output logic [ERR_W-1:0] error_count
);

    localparam int IDLE_W = $clog2(IDLE_TIMEOUT + 1);

    logic              clk_s1;      // Clock line synchronizer
    logic              clk_s2;
    logic              clk_prev;    // Edge register
    logic              data_s1;     // Data line synchronizer
    logic              data_s2;
    logic              clk_fall;
    logic [3:0]        bit_cnt;     // Bits received so far in this frame
    logic [9:0]        frame_sr;    // Start, data and parity, LSB first
    logic [IDLE_W-1:0] idle_cnt;
    logic              in_frame;
    logic              idle_expired;
    logic              frame_ok;

    // PS/2 clock idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            clk_s1   <= 1'b1;
            clk_s2   <= 1'b1;
            clk_prev <= 1'b1;
        end else begin
            clk_s1   <= ps2_clk;
            clk_s2   <= clk_s1;
            clk_prev <= clk_s2;
        end
    end

    always_ff @(posedge clk) begin
        data_s1 <= ps2_data;
        data_s2 <= data_s1;
    end

    assign clk_fall = clk_prev & ~clk_s2;  // Data is sampled on this edge
    assign in_frame = (bit_cnt != 4'd0);
    assign idle_expired = in_frame && !clk_fall &&
                          (idle_cnt == IDLE_W'(IDLE_TIMEOUT - 1));

    // Stop bit is the live sample and the rest sits in the shift register
    // Start 0, stop 1, odd parity over data and parity bit
    assign frame_ok = ~frame_sr[0] & data_s2 & (^frame_sr[9:1]);

    // Frame assembler
    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt  <= 4'd0;
            rx_valid <= 1'b0;
            rx_error <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            rx_error <= 1'b0;
            if (clk_fall) begin
                if (bit_cnt == 4'd10) begin  // Stop bit
                    bit_cnt  <= 4'd0;
                    rx_valid <= frame_ok;
                    rx_error <= ~frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (idle_expired) begin
                bit_cnt  <= 4'd0;  // Drop the partial frame
                rx_error <= 1'b1;
            end
        end
    end

    // Shift register and received byte
    always_ff @(posedge clk) begin
        if (clk_fall) begin
            frame_sr <= {data_s2, frame_sr[9:1]};
        end
        if (clk_fall && bit_cnt == 4'd10) begin
            rx_byte <= frame_sr[8:1];
        end
    end

    // Idle watchdog runs only inside a frame
    always_ff @(posedge clk) begin
        if (reset) begin
            idle_cnt <= '0;
        end else if (clk_fall || !in_frame) begin
            idle_cnt <= '0;
        end else begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    // Bad frame counter
    always_ff @(posedge clk) begin
        if (reset) begin
            error_count <= '0;
        end else if (rx_error && error_count != '1) begin  // Saturate at all ones
            error_count <= error_count + 1'b1;
        end
    end

    // A frame ends either good or bad but never both
    a_valid_error_excl: assert property (
        @(posedge clk) disable iff (reset) !(rx_valid && rx_error)
    );

    // Frames are far apart, so a valid pulse is always a single cycle
    a_valid_single: assert property (
        @(posedge clk) disable iff (reset) rx_valid |=> !rx_valid
    );

endmodule

`default_nettype wire

/* source/ps2_pkg.sv */
`default_nettype none

// Shared constants for the PS/2 keyboard input path
package ps2_pkg;

    // Prefix bytes of scan code set 2
    localparam logic [7:0] CODE_EXTEND  = 8'hE0;  // Extended key follows
    localparam logic [7:0] CODE_RELEASE = 8'hF0;  // Break code follows

    // Arrow keys are only valid after the E0 prefix
    localparam logic [7:0] KEY_LEFT  = 8'h6B;
    localparam logic [7:0] KEY_RIGHT = 8'h74;
    localparam logic [7:0] KEY_UP    = 8'h75;
    localparam logic [7:0] KEY_DOWN  = 8'h72;

    // Plain keys are never extended
    localparam logic [7:0] KEY_CTRL  = 8'h14;  // Left control
    localparam logic [7:0] KEY_SPACE = 8'h29;
    localparam logic [7:0] KEY_COIN  = 8'h2E;  // Digit 5
    localparam logic [7:0] KEY_START = 8'h16;  // Digit 1
    localparam logic [7:0] KEY_RESET = 8'h04;  // F3

    // Arcade control word
    localparam int JOY_W = 8;

    // Bit positions inside the control word
    localparam int JOY_RIGHT   = 0;
    localparam int JOY_LEFT    = 1;
    localparam int JOY_DOWN    = 2;
    localparam int JOY_UP      = 3;
    localparam int JOY_BUTTON1 = 4;
    localparam int JOY_BUTTON2 = 5;
    localparam int JOY_COIN    = 6;
    localparam int JOY_START   = 7;

    // Bad frame counter width
    localparam int ERR_W = 8;

endpackage

`default_nettype wire
